//--- flist.f
hdl/wiscPkg.sv
hdl/instrDecode.sv
hdl/seqFsm.sv
hdl/pcCounter.sv
hdl/progStore.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/miniCore.sv
tests/miniCore_assertions.sv
tests/miniCoreTb.sv

//--- run.sh
#!/bin/sh
# compile and run the miniCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module miniCoreTb -f flist.f -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tests/miniCoreTb.sv
`timescale 1ns/1ps

module miniCoreTb;

	localparam int clkPeriod      = 8;
	localparam int drvDelay       = 1;
	localparam int numTests       = 6;
	// each run loads the store once and executes at most 32 instructions of 4 cycles
	localparam int runCycles      = wiscPkg::progDepth * 4 + wiscPkg::progDepth + 8;
	localparam int watchdogCycles = numTests * 2 * runCycles + 100;

	logic            clk;
	logic            rstN;
	logic            start;
	wiscPkg::progWrT progWr;
	wiscPkg::wbT     wb;
	logic            halted;
	logic            err;

	logic [15:0]     prog [wiscPkg::progDepth];  // program image, also read by the model
	int              progLen;
	logic [15:0]     mRegs [8];                  // model register file
	wiscPkg::wbT     expQ [$];                   // predicted writes in order
	string           testName;
	int              testsRun;
	int              testsFailed;
	int              checks;
	int              errors;

	wiscPkg::opcodeE i1Ops [8] = '{wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori,
		wiscPkg::opAndni, wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli};
	wiscPkg::opcodeE rOps [10] = '{wiscPkg::opAddSub, wiscPkg::opAddSub, wiscPkg::opRolRor,
		wiscPkg::opRolRor, wiscPkg::opXorAndn, wiscPkg::opXorAndn, wiscPkg::opSeq,
		wiscPkg::opSlt, wiscPkg::opSle, wiscPkg::opSco};
	logic [1:0]      rFunct [10] = '{2'd0, 2'd1, 2'd0, 2'd1, 2'd0, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0};
	wiscPkg::opcodeE brOps [4] = '{wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz,
		wiscPkg::opBgez};
	// per branch a register that takes it, then one that does not
	logic [2:0]      brRegs [8] = '{3'd1, 3'd2, 3'd2, 3'd1, 3'd3, 3'd2, 3'd2, 3'd3};

	miniCore i_dut (
		.clk    (clk),
		.rstN   (rstN),
		.progWr (progWr),
		.start  (start),
		.wb     (wb),
		.halted (halted),
		.err    (err)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("watchdog expired, the core never reached halt");
		$display("Done: errors found");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// instruction encoding
	function automatic logic [15:0] encI1(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [4:0] imm5);
		return {op, rs, rt, imm5};
	endfunction

	function automatic logic [15:0] encI2(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm8);
		return {op, rs, imm8};
	endfunction

	function automatic logic [15:0] encR(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] funct);
		return {op, rs, rt, rd, funct};
	endfunction

	function automatic logic [15:0] encJ(input logic [4:0] op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic newProgram();
		foreach (prog[i])
			prog[i] = 16'h0000;                      // halt everywhere
		progLen = 0;
	endtask

	task automatic emit(input logic [15:0] ins);
		prog[progLen] = ins;
		progLen++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// reference model
	function automatic logic [15:0] rotateLeft(input logic [15:0] v, input logic [3:0] n);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < int'(n); i++)
			r = {r[14:0], r[15]};
		return r;
	endfunction

	function automatic logic [15:0] rotateRight(input logic [15:0] v, input logic [3:0] n);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < int'(n); i++)
			r = {r[0], r[15:1]};
		return r;
	endfunction

	function automatic logic branchTaken(input wiscPkg::opcodeE op, input logic [15:0] v);
		case (op)
			wiscPkg::opBeqz: return v == 16'h0000;
			wiscPkg::opBnez: return v != 16'h0000;
			wiscPkg::opBltz: return v[15];
			default:         return !v[15];
		endcase
	endfunction

	task automatic predictRun(output logic expHalt, output logic expErr);
		logic [4:0]      pc;
		logic [4:0]      nextPc;
		logic [15:0]     ins;
		logic [15:0]     rs;
		logic [15:0]     rt;
		logic [15:0]     res;
		logic [15:0]     i5s;
		logic [15:0]     i5z;
		logic [15:0]     i8s;
		logic [15:0]     i8z;
		logic [15:0]     linkV;
		logic [15:0]     sum;
		logic [16:0]     wide;
		logic [2:0]      dst;
		logic            wr;
		logic            stop;
		wiscPkg::opcodeE op;
		wiscPkg::wbT     w;
		int              steps;
		pc      = '0;
		stop    = 1'b0;
		steps   = 0;
		expHalt = 1'b0;
		expErr  = 1'b0;                            // all 32 codes are assigned, none is illegal
		while (!stop && steps < 4 * wiscPkg::progDepth)
		begin
			ins    = prog[pc];
			op     = wiscPkg::opcodeE'(ins[15:11]);
			rs     = mRegs[ins[10:8]];
			rt     = mRegs[ins[7:5]];
			i5s    = {{11{ins[4]}}, ins[4:0]};
			i5z    = {11'b0, ins[4:0]};
			i8s    = {{8{ins[7]}}, ins[7:0]};
			i8z    = {8'b0, ins[7:0]};
			linkV  = {11'b0, pc + 5'd1};
			nextPc = pc + 5'd1;
			wide   = {1'b0, rs} + {1'b0, rt};
			wr     = 1'b1;
			dst    = ins[7:5];
			res    = '0;
			case (op)
				wiscPkg::opHalt:
				begin
					wr      = 1'b0;
					stop    = 1'b1;
					expHalt = 1'b1;
				end
				wiscPkg::opAddi:    res = rs + i5s;
				wiscPkg::opSubi:    res = i5s - rs;
				wiscPkg::opXori:    res = rs ^ i5z;
				wiscPkg::opAndni:   res = rs & ~i5z;
				wiscPkg::opRoli:    res = rotateLeft(rs, ins[3:0]);
				wiscPkg::opSlli:    res = rs << ins[3:0];
				wiscPkg::opRori:    res = rotateRight(rs, ins[3:0]);
				wiscPkg::opSrli:    res = rs >> ins[3:0];
				wiscPkg::opAddSub:  res = ins[0] ? rt - rs : rs + rt;
				wiscPkg::opRolRor:
					res = ins[0] ? rotateRight(rs, rt[3:0]) : rotateLeft(rs, rt[3:0]);
				wiscPkg::opXorAndn: res = ins[0] ? rs & ~rt : rs ^ rt;
				wiscPkg::opSeq:     res = {15'b0, rs == rt};
				wiscPkg::opSlt:     res = {15'b0, $signed(rs) < $signed(rt)};
				wiscPkg::opSle:     res = {15'b0, $signed(rs) <= $signed(rt)};
				wiscPkg::opSco:     res = {15'b0, wide[16]};
				wiscPkg::opLbi:
				begin
					res = i8s;
					dst = ins[10:8];
				end
				wiscPkg::opSlbi:
				begin
					res = (rs << 8) | i8z;
					dst = ins[10:8];
				end
				wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz, wiscPkg::opBgez:
				begin
					wr = 1'b0;
					sum = linkV + i8s;
					if (branchTaken(op, rs))
						nextPc = sum[4:0];
				end
				wiscPkg::opJ, wiscPkg::opJal:
				begin
					wr     = (op == wiscPkg::opJal);
					res    = linkV;
					dst    = 3'd7;
					sum    = linkV + {{5{ins[10]}}, ins[10:0]};
					nextPc = sum[4:0];
				end
				wiscPkg::opJr, wiscPkg::opJalr:
				begin
					wr     = (op == wiscPkg::opJalr);
					res    = linkV;
					dst    = 3'd7;
					sum    = rs + i8s;                  // old r7 when Rs is r7
					nextPc = sum[4:0];
				end
				default:
					wr = 1'b0;                         // nop, siic, st, ld, stu
			endcase
			if (ins[15:11] > 5'b11000)
				dst = ins[4:2];                      // R-format codes sit above lbi
			if (wr)
			begin
				w.valid  = 1'b1;
				w.regNum = dst;
				w.data   = res;
				expQ.push_back(w);
				mRegs[dst] = res;
			end
			pc = nextPc;
			steps++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// driving and checking
	task automatic nextCycle();
		@(posedge clk);
		#drvDelay;
	endtask

	task automatic loadProgram();
		nextCycle();
		for (int a = 0; a < wiscPkg::progDepth; a++)
		begin
			progWr.we   = 1'b1;
			progWr.addr = a[4:0];
			progWr.data = prog[a];
			nextCycle();
		end
		progWr = '0;
	endtask

	task automatic pulseStart();
		nextCycle();
		start = 1'b1;
		nextCycle();
		start = 1'b0;
	endtask

	always @(negedge clk)
	begin : wbMonitor
		wiscPkg::wbT expW;
		if (rstN && wb.valid)
		begin
			if (expQ.size() == 0)
			begin
				$display("test %s: write to r%0d = %h when none was expected",
					testName, wb.regNum, wb.data);
				errors++;
			end
			else
			begin
				expW = expQ.pop_front();
				checks++;
				assert (wb == expW)
				else
				begin
					$display("Mismatch %s: expected r%0d = %h, actual r%0d = %h",
						testName, expW.regNum, expW.data, wb.regNum, wb.data);
					errors++;
				end
			end
		end
	end

	task automatic runTest(input string name, input bit reload);
		logic expHalt;
		logic expErr;
		int   errsBefore;
		testName   = name;
		errsBefore = errors;
		predictRun(expHalt, expErr);
		if (reload)
			loadProgram();
		pulseStart();
		do
			@(negedge clk);
		while (!(halted || err));
		@(negedge clk);
		assert (expQ.size() == 0)
		else
		begin
			$display("test %s: %0d expected writes never appeared", name, expQ.size());
			errors++;
		end
		assert (halted == expHalt && err == expErr)
		else
		begin
			$display("test %s: core stopped with halted %b err %b, expected halted %b err %b",
				name, halted, err, expHalt, expErr);
			errors++;
		end
		expQ.delete();
		testsRun++;
		if (errors == errsBefore)
			$display("test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("test %s: failed", name);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// tests
	task automatic testLbiAlu();
		newProgram();
		emit(encI2(wiscPkg::opLbi, 3'd1, 8'($urandom)));
		emit(encI2(wiscPkg::opSlbi, 3'd1, 8'($urandom)));
		emit(encI2(wiscPkg::opLbi, 3'd2, 8'($urandom)));
		emit(encI2(wiscPkg::opSlbi, 3'd2, 8'($urandom)));
		for (int k = 0; k < 16; k++)
			emit(encI1(i1Ops[k % 8], 3'($urandom_range(6, 1)), 3'($urandom_range(6, 1)),
				5'($urandom)));
		runTest("lbiAlu", 1'b1);
	endtask

	task automatic testRFormat();
		newProgram();
		for (int r = 0; r < 7; r++)
		begin
			emit(encI2(wiscPkg::opLbi, 3'(r), 8'($urandom)));
			emit(encI2(wiscPkg::opSlbi, 3'(r), 8'($urandom)));
		end
		for (int k = 0; k < 10; k++)
			emit(encR(rOps[k], 3'($urandom_range(6, 0)), 3'($urandom_range(6, 0)),
				3'($urandom_range(6, 0)), rFunct[k]));
		emit(encR(wiscPkg::opSeq, 3'd3, 3'd3, 3'd4, 2'd0)); // equal operands give 1
		runTest("rFormat", 1'b1);
	endtask

	task automatic testBranches();
		newProgram();
		emit(encI2(wiscPkg::opLbi, 3'd1, 8'h00));
		emit(encI2(wiscPkg::opLbi, 3'd2, 8'h05));
		emit(encI2(wiscPkg::opLbi, 3'd3, 8'hFD));      // negative
		for (int b = 0; b < 4; b++)
			for (int t = 0; t < 2; t++)
			begin
				emit(encI2(brOps[b], brRegs[2 * b + t], 8'd1));
				emit(encI2(wiscPkg::opLbi, 3'd4, 8'(16 * b + 2 * t)));
				emit(encI2(wiscPkg::opLbi, 3'd5, 8'(16 * b + 2 * t + 1)));
			end
		runTest("branch", 1'b1);
	endtask

	task automatic testJumps();
		newProgram();
		emit(encJ(wiscPkg::opJ, 11'd2));              // 0 -> 3
		emit(encI2(wiscPkg::opLbi, 3'd1, 8'h01));
		emit(encI2(wiscPkg::opLbi, 3'd1, 8'h02));
		emit(encJ(wiscPkg::opJal, 11'd1));            // 3 -> 5
		emit(encI2(wiscPkg::opLbi, 3'd2, 8'h04));
		emit(encI2(wiscPkg::opLbi, 3'd3, 8'd9));
		emit(encI2(wiscPkg::opJr, 3'd3, 8'd2));       // 6 -> 11
		for (int k = 7; k < 11; k++)
			emit(encI2(wiscPkg::opLbi, 3'd2, 8'(k)));
		emit(encI2(wiscPkg::opJalr, 3'd3, 8'd4));     // 11 -> 13
		emit(encI2(wiscPkg::opLbi, 3'd2, 8'h0C));
		emit(encJ(wiscPkg::opJ, 11'd3));              // 13 -> 17
		emit(encI2(wiscPkg::opLbi, 3'd6, 8'h0E));
		emit(16'h0000);
		emit(encI2(wiscPkg::opLbi, 3'd2, 8'h10));
		emit(encJ(wiscPkg::opJ, 11'h7FC));            // 17 -> 14, backward
		runTest("jump", 1'b1);
	endtask

	task automatic testHaltRerun();
		newProgram();
		emit(encI2(wiscPkg::opLbi, 3'd1, 8'($urandom)));
		emit(encI2(wiscPkg::opSlbi, 3'd1, 8'($urandom)));
		emit(encI1(wiscPkg::opAddi, 3'd1, 3'd2, 5'($urandom)));
		emit(16'h0000);
		emit(encI2(wiscPkg::opLbi, 3'd3, 8'h77));      // past the halt
		runTest("haltRun", 1'b1);
		runTest("haltRerun", 1'b0);
	endtask

	task automatic testNoWrite();
		newProgram();
		emit(encI2(wiscPkg::opLbi, 3'd1, 8'h5A));
		emit(encJ(wiscPkg::opNop, 11'($urandom)));
		emit(encJ(wiscPkg::opSiic, 11'($urandom)));
		emit(encJ(wiscPkg::opSt, 11'($urandom)));
		emit(encJ(wiscPkg::opLd, 11'($urandom)));
		emit(encJ(wiscPkg::opStu, 11'($urandom)));
		emit(encJ(wiscPkg::opNop2, 11'($urandom)));
		emit(encI2(wiscPkg::opLbi, 3'd2, 8'h5B));
		runTest("noWrite", 1'b1);
	endtask

	initial
	begin
		void'($urandom(72));
		rstN        = 1'b0;
		start       = 1'b0;
		progWr      = '0;
		testsRun    = 0;
		testsFailed = 0;
		checks      = 0;
		errors      = 0;
		foreach (mRegs[i])
			mRegs[i] = '0;                           // register file clears at reset
		repeat (5) @(posedge clk);
		#drvDelay rstN = 1'b1;
		testLbiAlu();
		testRFormat();
		testBranches();
		testJumps();
		testHaltRerun();
		testNoWrite();
		$display("tests %0d, failed %0d, writes checked %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- tests/miniCore_assertions.sv
`timescale 1ns/1ps

module miniCoreAssertions (
	input logic        clk,
	input logic        rstN,
	input wiscPkg::wbT wb,
	input logic        halted,
	input logic        err
);

	// the strobe covers only the stWrite cycle
	wbOneCycle : assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |=> !wb.valid)
		else $error("wb.valid stayed high for two cycles");

	// one instruction takes four cycles
	wbSpacing : assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |=> !wb.valid ##1 !wb.valid ##1 !wb.valid)
		else $error("two wb strobes closer than four cycles");

	resetLevels : assert property (@(posedge clk)
		!rstN |=> (!halted && !err))
		else $error("halted or err high right after reset");

	stoppedQuiet : assert property (@(posedge clk) disable iff (!rstN)
		(halted || err) |-> !wb.valid)
		else $error("register write while the core is stopped");

endmodule

bind miniCore miniCoreAssertions uAssertions (
	.clk    (clk),
	.rstN   (rstN),
	.wb     (wb),
	.halted (halted),
	.err    (err)
);

//--- hdl/miniCore.sv
`timescale 1ns/1ps

module miniCore (
	input  logic            clk,
	input  logic            rstN,
	input  wiscPkg::progWrT progWr,
	input  logic            start,
	output wiscPkg::wbT     wb,
	output logic            halted,
	output logic            err
);

	wiscPkg::coreStateE            state;
	wiscPkg::ctrlT                 ctrl;
	wiscPkg::ctrlT                 ctrlQ;         // decode held for exec and write
	wiscPkg::progWrT               progWrGated;
	logic [wiscPkg::dataW-1:0]     instr;
	logic [wiscPkg::dataW-1:0]     rsData;
	logic [wiscPkg::dataW-1:0]     rtData;
	logic [wiscPkg::dataW-1:0]     result;
	logic [wiscPkg::progAddrW-1:0] pc;
	logic [wiscPkg::progAddrW-1:0] pcNext;
	logic [wiscPkg::progAddrW-1:0] target;
	logic [wiscPkg::regAddrW-1:0]  rsAddr;
	logic [wiscPkg::regAddrW-1:0]  rtAddr;
	logic [wiscPkg::regAddrW-1:0]  rdAddr;
	logic [wiscPkg::regAddrW-1:0]  wrReg;
	logic                          fetchEn;
	logic                          pcInc;
	logic                          pcLoad;
	logic                          pcClear;
	logic                          regWe;
	logic                          takeBranch;
	logic                          validIns;

	assign rsAddr   = instr[10:8];
	assign rtAddr   = instr[7:5];
	assign rdAddr   = instr[4:2];
	assign validIns = (state == wiscPkg::stDecode) || (state == wiscPkg::stExec) ||
	                  (state == wiscPkg::stWrite);

	// program loads only while the core is stopped
	always_comb
	begin
		progWrGated    = progWr;
		progWrGated.we = progWr.we &&
		                 ((state == wiscPkg::stIdle) || (state == wiscPkg::stHalt));
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			ctrlQ <= '0;
		else if (state == wiscPkg::stDecode)
			ctrlQ <= ctrl;
	end

	always_comb
	begin
		if (ctrlQ.link)
			wrReg = wiscPkg::linkReg;
		else if ((ctrlQ.aluOp == wiscPkg::opLbi) || (ctrlQ.aluOp == wiscPkg::opSlbi))
			wrReg = rsAddr;
		else if (ctrlQ.regDst)
			wrReg = rdAddr;                       // R-format
		else
			wrReg = rtAddr;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// blocks
	progStore uStore (
		.clk     (clk),
		.progWr  (progWrGated),
		.fetchEn (fetchEn),
		.pc      (pc),
		.instr   (instr)
	);

	instrDecode uDecode (
		.opcode   (wiscPkg::opcodeE'(instr[15:11])),
		.validIns (validIns),
		.ctrl     (ctrl)
	);

	seqFsm uSeq (
		.clk        (clk),
		.rstN       (rstN),
		.start      (start),
		.ctrl       (ctrl),
		.takeBranch (takeBranch),
		.state      (state),
		.fetchEn    (fetchEn),
		.pcInc      (pcInc),
		.pcLoad     (pcLoad),
		.pcClear    (pcClear),
		.regWe      (regWe),
		.halted     (halted),
		.err        (err)
	);

	pcCounter uPc (
		.clk    (clk),
		.rstN   (rstN),
		.clear  (pcClear),
		.pcInc  (pcInc),
		.pcLoad (pcLoad),
		.target (target),
		.pc     (pc),
		.pcNext (pcNext)
	);

	regFile uRegs (
		.clk    (clk),
		.rstN   (rstN),
		.rsAddr (rsAddr),
		.rtAddr (rtAddr),
		.rsData (rsData),
		.rtData (rtData),
		.wrReg  (wrReg),
		.wrData (result),
		.regWe  (regWe),
		.wb     (wb)
	);

	aluUnit uAlu (
		.clk        (clk),
		.ctrl       (ctrlQ),
		.instr      (instr),
		.rsData     (rsData),
		.rtData     (rtData),
		.pcNext     (pcNext),
		.result     (result),
		.target     (target),
		.takeBranch (takeBranch)
	);

endmodule

//--- hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  logic                          clk,
	input  wiscPkg::ctrlT                 ctrl,
	input  logic [wiscPkg::dataW-1:0]     instr,
	input  logic [wiscPkg::dataW-1:0]     rsData,
	input  logic [wiscPkg::dataW-1:0]     rtData,
	input  logic [wiscPkg::progAddrW-1:0] pcNext,
	output logic [wiscPkg::dataW-1:0]     result,
	output logic [wiscPkg::progAddrW-1:0] target,
	output logic                          takeBranch
);

	logic [wiscPkg::dataW-1:0]   imm;
	logic [wiscPkg::dataW-1:0]   opB;
	logic [wiscPkg::dataW-1:0]   linkVal;
	logic [wiscPkg::dataW-1:0]   aluOut;
	logic [wiscPkg::dataW-1:0]   addrBase;
	logic [wiscPkg::dataW-1:0]   addrOff;
	logic [wiscPkg::dataW-1:0]   addrSum;
	logic [2*wiscPkg::dataW-1:0] rotL;
	logic [2*wiscPkg::dataW-1:0] rotR;
	logic [wiscPkg::dataW:0]     carrySum;
	logic [3:0]                  shAmt;
	logic                        cond;
	logic                        useFunct;

	// ~~~~~~~~~~~~~~~~~~~~
	// operands
	always_comb
	begin
		if (ctrl.i1Fmt)
			imm = ctrl.zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
		else
			imm = ctrl.zeroExt ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
	end

	assign opB      = ctrl.aluSrc ? imm : rtData;
	assign shAmt    = opB[3:0];
	assign rotL     = {rsData, rsData} << shAmt;      // upper half is the rotate
	assign rotR     = {rsData, rsData} >> shAmt;
	assign carrySum = {1'b0, rsData} + {1'b0, opB};
	assign linkVal  = {{(wiscPkg::dataW-wiscPkg::progAddrW){1'b0}}, pcNext};
	assign useFunct = instr[0];                      // second function of an R pair

	// ~~~~~~~~~~~~~~~~~~~~
	// operation, sub is B - A
	always_comb
	begin
		case (ctrl.aluOp)
			wiscPkg::opAddi:    aluOut = carrySum[wiscPkg::dataW-1:0];
			wiscPkg::opSubi:    aluOut = opB - rsData;
			wiscPkg::opXori:    aluOut = rsData ^ opB;
			wiscPkg::opAndni:   aluOut = rsData & ~opB;
			wiscPkg::opRoli:    aluOut = rotL[2*wiscPkg::dataW-1:wiscPkg::dataW];
			wiscPkg::opSlli:    aluOut = rsData << shAmt;
			wiscPkg::opRori:    aluOut = rotR[wiscPkg::dataW-1:0];
			wiscPkg::opSrli:    aluOut = rsData >> shAmt;
			wiscPkg::opAddSub:
				aluOut = useFunct ? opB - rsData : carrySum[wiscPkg::dataW-1:0];
			wiscPkg::opRolRor:
				aluOut = useFunct ? rotR[wiscPkg::dataW-1:0]
				                  : rotL[2*wiscPkg::dataW-1:wiscPkg::dataW];
			wiscPkg::opXorAndn: aluOut = useFunct ? rsData & ~opB : rsData ^ opB;
			wiscPkg::opSeq:     aluOut = wiscPkg::dataW'(rsData == opB);
			wiscPkg::opSlt:     aluOut = wiscPkg::dataW'($signed(rsData) < $signed(opB));
			wiscPkg::opSle:     aluOut = wiscPkg::dataW'($signed(rsData) <= $signed(opB));
			wiscPkg::opSco:     aluOut = wiscPkg::dataW'(carrySum[wiscPkg::dataW]);
			wiscPkg::opLbi:     aluOut = imm;
			wiscPkg::opSlbi:    aluOut = (rsData << 8) | imm;
			wiscPkg::opJal, wiscPkg::opJalr:
				aluOut = linkVal;
			default:            aluOut = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// branch condition and next pc
	always_comb
	begin
		case (ctrl.aluOp)
			wiscPkg::opBeqz: cond = (rsData == '0);
			wiscPkg::opBnez: cond = (rsData != '0);
			wiscPkg::opBltz: cond = rsData[wiscPkg::dataW-1];
			wiscPkg::opBgez: cond = !rsData[wiscPkg::dataW-1];
			default:         cond = 1'b0;
		endcase
	end

	assign takeBranch = ctrl.branch && cond;

	always_comb
	begin
		if (ctrl.jump && ctrl.aluSrc)
		begin
			addrBase = rsData;                    // jr, jalr
			addrOff  = imm;
		end
		else if (ctrl.jump)
		begin
			addrBase = linkVal;
			addrOff  = {{5{instr[10]}}, instr[10:0]};
		end
		else
		begin
			addrBase = linkVal;
			addrOff  = imm;
		end
	end

	assign addrSum = addrBase + addrOff;

	// inputs hold still from stExec through stWrite, so this holds the stExec value
	always_ff @(posedge clk)
	begin
		result <= aluOut;
		target <= addrSum[wiscPkg::progAddrW-1:0];
	end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [wiscPkg::regAddrW-1:0] rsAddr,
	input  logic [wiscPkg::regAddrW-1:0] rtAddr,
	output logic [wiscPkg::dataW-1:0]    rsData,
	output logic [wiscPkg::dataW-1:0]    rtData,
	input  logic [wiscPkg::regAddrW-1:0] wrReg,
	input  logic [wiscPkg::dataW-1:0]    wrData,
	input  logic                         regWe,
	output wiscPkg::wbT                  wb
);

	logic [wiscPkg::dataW-1:0] regs [wiscPkg::numRegs];

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

	// the strobe mirrors the write port, so it lasts exactly the stWrite cycle
	assign wb.valid  = regWe;
	assign wb.regNum = wrReg;
	assign wb.data   = wrData;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			regs <= '{default: '0};
		else if (regWe)
			regs[wrReg] <= wrData;
	end

endmodule

//--- hdl/progStore.sv
`timescale 1ns/1ps

module progStore (
	input  logic                          clk,
	input  wiscPkg::progWrT               progWr,
	input  logic                          fetchEn,
	input  logic [wiscPkg::progAddrW-1:0] pc,
	output logic [wiscPkg::dataW-1:0]     instr
);

	logic [wiscPkg::dataW-1:0] mem [wiscPkg::progDepth];

	always_ff @(posedge clk)
	begin
		if (progWr.we)
			mem[progWr.addr] <= progWr.data;
		if (fetchEn)
			instr <= mem[pc];                     // held until the next fetch
	end

endmodule

//--- hdl/pcCounter.sv
`timescale 1ns/1ps

module pcCounter (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          clear,
	input  logic                          pcInc,
	input  logic                          pcLoad,
	input  logic [wiscPkg::progAddrW-1:0] target,
	output logic [wiscPkg::progAddrW-1:0] pc,
	output logic [wiscPkg::progAddrW-1:0] pcNext
);

	assign pcNext = pc + wiscPkg::progAddrW'(1); // link value and branch base

	always_ff @(posedge clk)
	begin
		if (!rstN || clear)
			pc <= '0;
		else if (pcLoad)
			pc <= target;                         // taken branch or jump
		else if (pcInc)
			pc <= pcNext;
	end

endmodule

//--- hdl/seqFsm.sv
`timescale 1ns/1ps

module seqFsm (
	input  logic               clk,
	input  logic               rstN,
	input  logic               start,
	input  wiscPkg::ctrlT      ctrl,
	input  logic               takeBranch,
	output wiscPkg::coreStateE state,
	output logic               fetchEn,
	output logic               pcInc,
	output logic               pcLoad,
	output logic               pcClear,
	output logic               regWe,
	output logic               halted,
	output logic               err
);

	wiscPkg::coreStateE nextState;
	logic               stopped;      // start is only taken here
	logic               redirect;

	assign stopped  = (state == wiscPkg::stIdle) || (state == wiscPkg::stHalt);
	assign redirect = ctrl.jump || takeBranch;
	assign pcClear  = stopped && start;
	assign fetchEn  = (state == wiscPkg::stFetch);
	assign regWe    = (state == wiscPkg::stWrite) && ctrl.regWrite;
	assign pcLoad   = (state == wiscPkg::stWrite) && redirect;
	assign pcInc    = (state == wiscPkg::stWrite) && !redirect;

	always_comb
	begin
		nextState = state;
		case (state)
			wiscPkg::stIdle, wiscPkg::stHalt:
				if (start)
					nextState = wiscPkg::stFetch;
			wiscPkg::stFetch:
				nextState = wiscPkg::stDecode;
			wiscPkg::stDecode:
				if (ctrl.err || ctrl.halt)
					nextState = wiscPkg::stHalt;  // nothing gets written
				else
					nextState = wiscPkg::stExec;
			wiscPkg::stExec:
				nextState = wiscPkg::stWrite;
			wiscPkg::stWrite:
				nextState = wiscPkg::stFetch;
			default:
				nextState = wiscPkg::stIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state  <= wiscPkg::stIdle;
			halted <= 1'b0;
			err    <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (pcClear)
			begin
				halted <= 1'b0;                   // levels hold until the next run
				err    <= 1'b0;
			end
			else if (state == wiscPkg::stDecode)
			begin
				halted <= ctrl.halt;
				err    <= ctrl.err;
			end
		end
	end

endmodule

//--- hdl/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  wiscPkg::opcodeE opcode,
	input  logic            validIns,
	output wiscPkg::ctrlT   ctrl
);

	wiscPkg::opcodeE effOp;

	assign effOp = validIns ? opcode : wiscPkg::opNop; // no valid fetch behaves as nop

	always_comb
	begin
		ctrl       = '0;
		ctrl.aluOp = effOp;
		case (effOp)
			wiscPkg::opHalt:
			begin
				ctrl.halt = 1'b1;
			end
			wiscPkg::opNop, wiscPkg::opNop2, wiscPkg::opSiic:
			begin
				ctrl.aluOp = effOp;               // nothing to do
			end
			// ~~~~~~~~~~~~~~~~~~~~
			// I-format 1
			wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opRoli, wiscPkg::opSlli,
			wiscPkg::opRori, wiscPkg::opSrli:
			begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.i1Fmt    = 1'b1;
			end
			wiscPkg::opXori, wiscPkg::opAndni:
			begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.i1Fmt    = 1'b1;
				ctrl.zeroExt  = 1'b1;             // logic ops take an unsigned imm
			end
			wiscPkg::opSt, wiscPkg::opLd, wiscPkg::opStu:
			begin
				ctrl.aluOp = effOp;               // no data memory, legal no-op
			end
			// ~~~~~~~~~~~~~~~~~~~~
			// R-format
			wiscPkg::opAddSub, wiscPkg::opRolRor, wiscPkg::opXorAndn, wiscPkg::opSeq,
			wiscPkg::opSlt, wiscPkg::opSle, wiscPkg::opSco:
			begin
				ctrl.regDst   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// ~~~~~~~~~~~~~~~~~~~~
			// I-format 2
			wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz, wiscPkg::opBgez:
			begin
				ctrl.aluSrc = 1'b1;
				ctrl.branch = 1'b1;
			end
			wiscPkg::opLbi:
			begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;             // writes Rs
			end
			wiscPkg::opSlbi:
			begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.zeroExt  = 1'b1;
			end
			// ~~~~~~~~~~~~~~~~~~~~
			// J-format
			wiscPkg::opJ:
			begin
				ctrl.jump = 1'b1;
			end
			wiscPkg::opJr:
			begin
				ctrl.jump   = 1'b1;
				ctrl.aluSrc = 1'b1;               // target from Rs+imm8
			end
			wiscPkg::opJal:
			begin
				ctrl.jump     = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.link     = 1'b1;
			end
			wiscPkg::opJalr:
			begin
				ctrl.jump     = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.link     = 1'b1;
			end
			default:
			begin
				ctrl.err = 1'b1;
			end
		endcase
	end

endmodule

//--- hdl/wiscPkg.sv
package wiscPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// sizes
	localparam int dataW     = 16;            // data and instruction width
	localparam int regAddrW  = 3;
	localparam int numRegs   = 1 << regAddrW;
	localparam int progDepth = 32;
	localparam int progAddrW = 5;             // pc counts words
	localparam logic [regAddrW-1:0] linkReg = 3'd7; // return address of jal and jalr

	// ~~~~~~~~~~~~~~~~~~~~
	// opcodes, bits 15:11 of the instruction
	typedef enum logic [4:0] {
		opHalt    = 5'b00000,
		opNop     = 5'b00001,
		opSiic    = 5'b00010,
		opNop2    = 5'b00011,
		opJ       = 5'b00100,
		opJr      = 5'b00101,
		opJal     = 5'b00110,
		opJalr    = 5'b00111,
		opAddi    = 5'b01000,
		opSubi    = 5'b01001,
		opXori    = 5'b01010,
		opAndni   = 5'b01011,
		opBeqz    = 5'b01100,
		opBnez    = 5'b01101,
		opBltz    = 5'b01110,
		opBgez    = 5'b01111,
		opSt      = 5'b10000,
		opLd      = 5'b10001,
		opSlbi    = 5'b10010,
		opStu     = 5'b10011,
		opRoli    = 5'b10100,
		opSlli    = 5'b10101,
		opRori    = 5'b10110,
		opSrli    = 5'b10111,
		opLbi     = 5'b11000,
		opAddSub  = 5'b11001,             // funct[0] picks sub
		opRolRor  = 5'b11010,             // funct[0] picks ror
		opXorAndn = 5'b11011,             // funct[0] picks andn
		opSeq     = 5'b11100,
		opSlt     = 5'b11101,
		opSle     = 5'b11110,
		opSco     = 5'b11111
	} opcodeE;

	typedef enum logic [2:0] {
		stIdle,
		stFetch,
		stDecode,
		stExec,
		stWrite,
		stHalt
	} coreStateE;

	// ~~~~~~~~~~~~~~~~~~~~
	// bundles
	typedef struct packed {
		logic   regDst;                   // write Rd (4:2) instead of Rt (7:5)
		logic   aluSrc;                   // second operand is the immediate
		logic   branch;
		logic   jump;
		logic   regWrite;
		logic   halt;
		logic   zeroExt;
		logic   i1Fmt;                    // 5 bit immediate
		logic   link;                     // r7 gets pc+1
		logic   err;                      // illegal opcode
		opcodeE aluOp;
	} ctrlT;

	typedef struct packed {
		logic                valid;
		logic [regAddrW-1:0] regNum;      // destination register
		logic [dataW-1:0]    data;
	} wbT;

	typedef struct packed {
		logic                 we;
		logic [progAddrW-1:0] addr;
		logic [dataW-1:0]     data;
	} progWrT;

endpackage
